/* dv/lsq_mem_tests.txt */
// columns: name rw addr wdata wb_tag burst exp_fwd exp_data
// burst 1 = next request follows with no idle cycle
11 0 00000040 00000000 1 0 0 00000010
21 1 00000100 A5A50001 2 0 0 A5A50001
22 0 00000100 00000000 3 0 1 A5A50001
23 1 00000104 12345678 4 0 0 12345678
24 1 00000100 CAFE0002 5 0 0 CAFE0002
25 0 00000100 00000000 6 0 1 CAFE0002
26 0 00000104 00000000 7 0 1 12345678
31 1 00000200 0BAD0200 8 0 0 0BAD0200
32 1 00000204 00000204 9 0 0 00000204
33 1 00000208 00000208 A 0 0 00000208
34 1 0000020C 0000020C B 0 0 0000020C
35 1 00000210 00000210 C 0 0 00000210
36 0 00000200 00000000 D 0 0 0BAD0200
37 0 00000100 00000000 E 0 0 CAFE0002
51 0 00000000 00000000 0 1 0 00000000
52 0 00000210 00000000 1 1 1 00000210
53 1 00000300 11110300 2 1 0 11110300
54 0 00000300 00000000 3 1 1 11110300
55 0 00000204 00000000 4 1 0 00000204
56 0 00000008 00000000 5 1 0 00000002
57 1 00000008 22220008 6 1 0 22220008
58 0 00000008 00000000 7 1 1 22220008
59 0 00000208 00000000 8 1 0 00000208
5A 0 000000FC 00000000 9 1 0 0000003F
5B 0 0000020C 00000000 A 1 1 0000020C
5C 1 0000020C 3333020C B 1 0 3333020C
5D 0 0000020C 00000000 C 1 1 3333020C
5E 0 000003F8 00000000 D 1 0 000000FE
5F 0 00000040 00000000 E 1 0 00000010

/* flist.f */
rtl/lsq_pkg.sv
rtl/mem_pkg.sv
rtl/lsq_alloc.sv
rtl/store_fwd_table.sv
rtl/dcache_model.sv
rtl/lsq_retire.sv
rtl/lsq_mem_top.sv
dv/lsq_mem_assertions.sv
dv/tb_lsq_mem.sv

/* dv/tb_lsq_mem.sv */
// load/store queue testbench
`timescale 1ns/1ns

module tb_lsq_mem;
  import lsq_pkg::*;
  import mem_pkg::*;

  localparam int FWD_DEPTH  = 4;
  localparam int N_TESTS    = 29;
  localparam int N_COLS     = 8;            // name rw addr wdata tag burst fwd data
  localparam int MAX_CYCLES = 40 * N_TESTS; // run limit

  logic    clk;
  logic    rst;
  logic    i_req;
  logic    i_rw;
  addr_t   i_addr;
  data_t   i_wdata;
  wb_tag_t i_wb_tag;
  logic    o_full;
  logic    o_resp;
  data_t   o_resp_data;
  wb_tag_t o_resp_wb_tag;
  logic    o_resp_rw;
  logic    o_resp_fwd;

  logic [31:0] vec [N_TESTS*N_COLS]; // raw words from the test file

  // reference memory and forwarding table
  data_t ref_mem  [MEM_WORDS];
  logic  ref_vld  [FWD_DEPTH];
  addr_t ref_addr [FWD_DEPTH];
  data_t ref_data [FWD_DEPTH];
  int    ref_victim;

  // expected retirements, oldest first
  logic [7:0] q_name [$];
  logic       q_rw   [$];
  wb_tag_t    q_tag  [$];
  logic       q_fwd  [$];
  data_t      q_data [$];

  int          mism_errs;
  int          other_errs;
  logic [7:0]  last_name;
  int unsigned lcg_state = 41;

  lsq_mem_top #(.FWD_DEPTH(FWD_DEPTH), .MEM_WORDS(MEM_WORDS)) u_dut (
    .clk(clk), .rst(rst), .i_req(i_req), .i_rw(i_rw), .i_addr(i_addr),
    .i_wdata(i_wdata), .i_wb_tag(i_wb_tag), .o_full(o_full), .o_resp(o_resp),
    .o_resp_data(o_resp_data), .o_resp_wb_tag(o_resp_wb_tag),
    .o_resp_rw(o_resp_rw), .o_resp_fwd(o_resp_fwd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16; // upper bits, low ones cycle fast
  endfunction

  // apply one request to the model in request order
  task automatic predict(input logic rw, input addr_t addr, input data_t wdata,
                         output logic fwd, output data_t data);
    int hit;
    hit  = -1;
    fwd  = 1'b0;
    data = wdata; // stores echo their own data
    for (int i = 0; i < FWD_DEPTH; i++) begin
      if (ref_vld[i] && ref_addr[i] == addr) hit = i;
    end
    if (rw) begin
      ref_mem[addr[9:2]] = wdata;
      if (hit >= 0) begin
        ref_data[hit] = wdata; // update in place
      end else begin
        ref_vld[ref_victim]  = 1'b1;
        ref_addr[ref_victim] = addr;
        ref_data[ref_victim] = wdata;
        ref_victim = (ref_victim + 1) % FWD_DEPTH;
      end
    end else if (hit >= 0) begin
      fwd  = 1'b1;
      data = ref_data[hit];
    end else begin
      data = ref_mem[addr[9:2]];
    end
  endtask

  task automatic issue_request(input int idx);
    int    base;
    logic  exp_fwd;
    data_t exp_data;
    base      = idx * N_COLS;
    last_name = vec[base][7:0];
    i_req    <= 1'b1;
    i_rw     <= vec[base+1][0];
    i_addr   <= vec[base+2];
    i_wdata  <= vec[base+3];
    i_wb_tag <= vec[base+4][3:0];
    predict(vec[base+1][0], vec[base+2], vec[base+3], exp_fwd, exp_data);
    if (exp_fwd !== vec[base+6][0] || exp_data !== vec[base+7]) begin
      $display("test %02h: test file and reference model disagree on the result",
               last_name);
      other_errs++;
    end
    q_name.push_back(last_name);
    q_rw.push_back(vec[base+1][0]);
    q_tag.push_back(vec[base+4][3:0]);
    q_fwd.push_back(vec[base+6][0]);
    q_data.push_back(vec[base+7]);
  endtask

  // head of the expected queue against the retire outputs
  task automatic check_retire();
    logic [7:0] name;
    logic       rw;
    wb_tag_t    tag;
    logic       fwd;
    data_t      data;
    if (q_name.size() == 0) begin
      $display("retire pulse while no request is outstanding");
      other_errs++;
    end else begin
      name = q_name.pop_front();
      rw   = q_rw.pop_front();
      tag  = q_tag.pop_front();
      fwd  = q_fwd.pop_front();
      data = q_data.pop_front();
      if (o_resp_rw !== rw) begin
        $display("mismatch test %02h rw: expected %0b, actual %0b", name, rw, o_resp_rw);
        mism_errs++;
      end
      if (o_resp_wb_tag !== tag) begin
        $display("mismatch test %02h wb_tag: expected %0h, actual %0h", name, tag, o_resp_wb_tag);
        mism_errs++;
      end
      if (o_resp_fwd !== fwd) begin
        $display("mismatch test %02h fwd: expected %0b, actual %0b", name, fwd, o_resp_fwd);
        mism_errs++;
      end
      if (o_resp_data !== data) begin
        $display("mismatch test %02h data: expected %08h, actual %08h", name, data, o_resp_data);
        mism_errs++;
      end
    end
  endtask

  initial begin
    int idx;
    int gap;
    int cycles;
    int occ;
    idx = 0;
    gap = 0;
    cycles = 0;
    occ = 0; // live entries as the core sees them
    mism_errs = 0;
    other_errs = 0;
    last_name = '0;
    i_req = 1'b0;
    i_rw = 1'b0;
    i_addr = '0;
    i_wdata = '0;
    i_wb_tag = '0;
    rst = 1'b1;
    $readmemh("dv/lsq_mem_tests.txt", vec);
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = data_t'(i);
    for (int i = 0; i < FWD_DEPTH; i++) ref_vld[i] = 1'b0;
    ref_victim = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    while ((idx < N_TESTS || q_name.size() > 0) && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
      // outputs here still hold the values of the cycle just ending
      if (o_full !== (occ == LSQ_DEPTH)) begin
        $display("mismatch test %02h full: expected %0b, actual %0b",
                 last_name, (occ == LSQ_DEPTH), o_full);
        mism_errs++;
      end
      if (o_resp === 1'b1) check_retire();
      if (i_req && !o_full) occ++;
      if (o_resp === 1'b1) occ--;
      i_req <= 1'b0;
      if (gap > 0) begin
        gap--;
      end else if (idx < N_TESTS && occ < LSQ_DEPTH) begin
        issue_request(idx);
        gap = vec[idx*N_COLS+5][0] ? 0 : int'(next_rand() % 4); // burst rows back to back
        idx++;
      end
    end

    if (idx < N_TESTS || q_name.size() > 0) begin
      $display("timeout after %0d cycles with %0d requests unissued and %0d not retired",
               cycles, N_TESTS - idx, q_name.size());
      other_errs++;
    end
    $display("errors: %0d mismatch, %0d other, %0d assertion",
             mism_errs, other_errs, u_dut.u_asrt.fail_cnt);
    if (mism_errs == 0 && other_errs == 0 && u_dut.u_asrt.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* dv/lsq_mem_assertions.sv */
// queue protocol checks
`timescale 1ns/1ns

module lsq_mem_assertions (
  input logic clk,
  input logic rst,
  input logic i_req,
  input logic i_full,
  input logic i_resp
);
  import lsq_pkg::*;

  lsq_cnt_t occ;          // own count of live entries
  int       fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else if (i_req && !i_full && !i_resp) begin
      occ <= occ + 1'b1;
    end else if (i_resp && !(i_req && !i_full)) begin
      occ <= occ - 1'b1;
    end
  end

  a_no_req_when_full: assert property (@(posedge clk) disable iff (rst) i_full |-> !i_req)
    else begin
      $error("request while queue full");
      fail_cnt++;
    end

  a_no_resp_when_empty: assert property (@(posedge clk) disable iff (rst)
    (occ == '0) |-> !i_resp)
    else begin
      $error("retire from an empty queue");
      fail_cnt++;
    end

  // full drops only through a retirement
  a_full_falls_on_resp: assert property (@(posedge clk) disable iff (rst)
    $fell(i_full) |-> $past(i_resp))
    else begin
      $error("full fell without a retire");
      fail_cnt++;
    end

endmodule

bind lsq_mem_top lsq_mem_assertions u_asrt (
  .clk(clk), .rst(rst), .i_req(i_req), .i_full(o_full), .i_resp(o_resp)
);

/* rtl/lsq_mem_top.sv */
// load/store queue with data memory
`timescale 1ns/1ns

module lsq_mem_top #(
  parameter int FWD_DEPTH = 4,
  parameter int MEM_WORDS = mem_pkg::MEM_WORDS
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_req,         // one request per cycle at most
  input  logic             i_rw,          // 1 = store
  input  mem_pkg::addr_t   i_addr,
  input  mem_pkg::data_t   i_wdata,
  input  lsq_pkg::wb_tag_t i_wb_tag,
  output logic             o_full,
  output logic             o_resp,        // retire pulse, also lowers the count
  output mem_pkg::data_t   o_resp_data,
  output lsq_pkg::wb_tag_t o_resp_wb_tag,
  output logic             o_resp_rw,
  output logic             o_resp_fwd
);
  import lsq_pkg::*;
  import mem_pkg::*;

  logic    alloc_en;
  lsq_id_t alloc_id;
  logic    mem_valid;  // store or forwarding miss
  logic    fwd_hit;
  data_t   fwd_data;
  logic    rsp_valid;
  lsq_id_t rsp_id;
  data_t   rsp_data;

  lsq_alloc u_alloc (
    .clk(clk), .rst(rst), .i_req(i_req), .i_rw(i_rw),
    .i_fwd_hit(fwd_hit), .i_retire_en(o_resp),
    .o_alloc_en(alloc_en), .o_alloc_id(alloc_id),
    .o_mem_valid(mem_valid), .o_full(o_full)
  );

  store_fwd_table #(.FWD_DEPTH(FWD_DEPTH)) u_fwd (
    .clk(clk), .rst(rst), .i_req_en(alloc_en), .i_rw(i_rw),
    .i_addr(i_addr), .i_wdata(i_wdata),
    .o_fwd_hit(fwd_hit), .o_fwd_data(fwd_data)
  );

  dcache_model #(.MEM_WORDS(MEM_WORDS)) u_dcache (
    .clk(clk), .rst(rst), .i_valid(mem_valid), .i_rw(i_rw),
    .i_addr(i_addr), .i_wdata(i_wdata), .i_id(alloc_id),
    .o_rsp_valid(rsp_valid), .o_rsp_id(rsp_id), .o_rsp_data(rsp_data)
  );

  lsq_retire u_retire (
    .clk(clk), .rst(rst), .i_alloc_en(alloc_en), .i_alloc_id(alloc_id),
    .i_rw(i_rw), .i_wb_tag(i_wb_tag), .i_fwd_hit(fwd_hit), .i_fwd_data(fwd_data),
    .i_rsp_valid(rsp_valid), .i_rsp_id(rsp_id), .i_rsp_data(rsp_data),
    .o_retire_en(o_resp), .o_resp_data(o_resp_data), .o_resp_wb_tag(o_resp_wb_tag),
    .o_resp_rw(o_resp_rw), .o_resp_fwd(o_resp_fwd)
  );

endmodule

/* rtl/lsq_retire.sv */
// queue entries and in-order retire
`timescale 1ns/1ns

module lsq_retire (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_alloc_en,
  input  lsq_pkg::lsq_id_t i_alloc_id,
  input  logic             i_rw,          // 1 = store
  input  lsq_pkg::wb_tag_t i_wb_tag,
  input  logic             i_fwd_hit,     // load served by forwarding table
  input  mem_pkg::data_t   i_fwd_data,
  input  logic             i_rsp_valid,   // memory response strobe
  input  lsq_pkg::lsq_id_t i_rsp_id,
  input  mem_pkg::data_t   i_rsp_data,
  output logic             o_retire_en,   // one-cycle retire pulse
  output mem_pkg::data_t   o_resp_data,
  output lsq_pkg::wb_tag_t o_resp_wb_tag,
  output logic             o_resp_rw,
  output logic             o_resp_fwd
);
  import lsq_pkg::*;
  import mem_pkg::*;

  logic    ent_vld  [LSQ_DEPTH]; // entry holds a request
  logic    ent_rdy  [LSQ_DEPTH]; // data present, may retire
  data_t   ent_data [LSQ_DEPTH];
  wb_tag_t ent_tag  [LSQ_DEPTH];
  logic    ent_rw   [LSQ_DEPTH];
  logic    ent_fwd  [LSQ_DEPTH];
  lsq_id_t head_ptr;             // oldest entry

  // head leaves as soon as it is valid and ready
  assign o_retire_en   = ent_vld[head_ptr] & ent_rdy[head_ptr];
  assign o_resp_data   = ent_data[head_ptr];
  assign o_resp_wb_tag = ent_tag[head_ptr];
  assign o_resp_rw     = ent_rw[head_ptr];
  assign o_resp_fwd    = ent_fwd[head_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
        ent_vld[i] <= 1'b0;
        ent_rdy[i] <= 1'b0;
      end
      head_ptr <= '0;
    end else begin
      if (i_alloc_en) begin
        ent_vld[i_alloc_id] <= 1'b1;
        ent_rdy[i_alloc_id] <= i_fwd_hit; // forwarded load is done now
      end
      if (i_rsp_valid) begin
        ent_rdy[i_rsp_id] <= 1'b1;
      end
      // retire clears the head and moves on, never the tail entry
      if (o_retire_en) begin
        ent_vld[head_ptr] <= 1'b0;
        ent_rdy[head_ptr] <= 1'b0;
        if (head_ptr == lsq_id_t'(LSQ_DEPTH - 1)) begin
          head_ptr <= '0;
        end else begin
          head_ptr <= head_ptr + 1'b1;
        end
      end
    end
  end

  // entry payload, data later replaced by the memory response
  always_ff @(posedge clk) begin
    if (i_alloc_en) begin
      ent_data[i_alloc_id] <= i_fwd_data;
      ent_tag[i_alloc_id]  <= i_wb_tag;
      ent_rw[i_alloc_id]   <= i_rw;
      ent_fwd[i_alloc_id]  <= i_fwd_hit;
    end
    if (i_rsp_valid) begin
      ent_data[i_rsp_id] <= i_rsp_data;
    end
  end

endmodule

/* rtl/dcache_model.sv */
// data memory with fixed response delay
`timescale 1ns/1ns

module dcache_model #(
  parameter int MEM_WORDS = mem_pkg::MEM_WORDS
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,     // request this cycle
  input  logic             i_rw,        // 1 = write
  input  mem_pkg::addr_t   i_addr,
  input  mem_pkg::data_t   i_wdata,
  input  lsq_pkg::lsq_id_t i_id,        // queue entry of the request
  output logic             o_rsp_valid,
  output lsq_pkg::lsq_id_t o_rsp_id,
  output mem_pkg::data_t   o_rsp_data
);
  import lsq_pkg::*;
  import mem_pkg::*;

  data_t     mem_arr [MEM_WORDS];
  word_idx_t widx;

  // two delay stages ahead of the response registers
  logic    pipe_vld  [2];
  lsq_id_t pipe_id   [2];
  data_t   pipe_data [2];

  assign widx = i_addr[9:2]; // word addressed, low bits ignored

  // word i comes out of reset holding i
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_arr[i] <= data_t'(i);
      end
    end else if (i_valid && i_rw) begin
      mem_arr[widx] <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_vld[0] <= 1'b0;
      pipe_vld[1] <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      pipe_vld[0] <= i_valid;
      pipe_vld[1] <= pipe_vld[0];
      o_rsp_valid <= pipe_vld[1]; // high after the second edge past issue
    end
  end

  // id and data ride along, stores echo their write data
  always_ff @(posedge clk) begin
    pipe_id[0]   <= i_id;
    pipe_data[0] <= i_rw ? i_wdata : mem_arr[widx];
    pipe_id[1]   <= pipe_id[0];
    pipe_data[1] <= pipe_data[0];
    o_rsp_id     <= pipe_id[1];
    o_rsp_data   <= pipe_data[1];
  end

endmodule

/* rtl/store_fwd_table.sv */
// store to load forwarding table
`timescale 1ns/1ns

module store_fwd_table #(
  parameter int FWD_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           i_req_en,  // accepted request
  input  logic           i_rw,      // 1 = store
  input  mem_pkg::addr_t i_addr,
  input  mem_pkg::data_t i_wdata,
  output logic           o_fwd_hit, // load hit, same cycle
  output mem_pkg::data_t o_fwd_data
);
  import mem_pkg::*;

  // pointer needs at least one bit even for a single entry
  localparam int PTR_W = (FWD_DEPTH > 1) ? $clog2(FWD_DEPTH) : 1;

  logic             ent_vld  [FWD_DEPTH];
  addr_t            ent_addr [FWD_DEPTH];
  data_t            ent_data [FWD_DEPTH];
  logic [PTR_W-1:0] victim_ptr; // round-robin replace slot
  logic             match;
  logic [PTR_W-1:0] match_idx;

  // an address lives in at most one slot, stores update in place
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int i = 0; i < FWD_DEPTH; i++) begin
      if (ent_vld[i] && (ent_addr[i] == i_addr)) begin
        match     = 1'b1;
        match_idx = PTR_W'(i);
      end
    end
  end

  assign o_fwd_hit  = i_req_en & ~i_rw & match; // loads only
  assign o_fwd_data = ent_data[match_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < FWD_DEPTH; i++) begin
        ent_vld[i] <= 1'b0; // table starts empty
      end
      victim_ptr <= '0;
    end else if (i_req_en && i_rw && !match) begin
      ent_vld[victim_ptr] <= 1'b1;
      if (victim_ptr == PTR_W'(FWD_DEPTH - 1)) begin
        victim_ptr <= '0;
      end else begin
        victim_ptr <= victim_ptr + 1'b1;
      end
    end
  end

  // address and data of the newest store per slot
  always_ff @(posedge clk) begin
    if (i_req_en && i_rw) begin
      if (match) begin
        ent_data[match_idx] <= i_wdata; // same address, overwrite
      end else begin
        ent_addr[victim_ptr] <= i_addr;
        ent_data[victim_ptr] <= i_wdata;
      end
    end
  end

endmodule

/* rtl/lsq_alloc.sv */
// queue allocation and request steering
`timescale 1ns/1ns

module lsq_alloc (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_req,       // one-cycle strobe from core
  input  logic             i_rw,        // 1 = store
  input  logic             i_fwd_hit,   // load found in forwarding table
  input  logic             i_retire_en, // head left the queue this cycle
  output logic             o_alloc_en,
  output lsq_pkg::lsq_id_t o_alloc_id,
  output logic             o_mem_valid,
  output logic             o_full
);
  import lsq_pkg::*;

  lsq_id_t  tail_ptr; // next entry to hand out
  lsq_cnt_t occ_cnt;  // live entries

  // a request seen while full is simply dropped
  assign o_alloc_en = i_req & ~o_full;
  assign o_alloc_id = tail_ptr;

  // stores always write memory, loads only when not forwarded
  assign o_mem_valid = o_alloc_en & (i_rw | ~i_fwd_hit);

  assign o_full = (occ_cnt == lsq_cnt_t'(LSQ_DEPTH)); // level, from the count

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
      occ_cnt  <= '0;
    end else begin
      // tail wraps after the last entry
      if (o_alloc_en) begin
        if (tail_ptr == lsq_id_t'(LSQ_DEPTH - 1)) begin
          tail_ptr <= '0;
        end else begin
          tail_ptr <= tail_ptr + 1'b1;
        end
      end

      // alloc and retire together leave the count alone
      case ({o_alloc_en, i_retire_en})
        2'b10:   occ_cnt <= occ_cnt + 1'b1;
        2'b01:   occ_cnt <= occ_cnt - 1'b1;
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

endmodule

/* rtl/mem_pkg.sv */
// data memory types
package mem_pkg;

  typedef logic [31:0] addr_t; // byte address from the core
  typedef logic [31:0] data_t; // one memory word

  // words in the data memory model
  localparam int MEM_WORDS = 256;

  // word index, address bits 9:2
  typedef logic [7:0] word_idx_t;

endpackage

/* rtl/lsq_pkg.sv */
// load/store queue types
package lsq_pkg;

  // 15 live entries, id 15 never handed out
  localparam int LSQ_DEPTH = 15;

  // queue entry index, 0 to LSQ_DEPTH-1
  typedef logic [3:0] lsq_id_t;

  // number of live entries, 0 to LSQ_DEPTH
  typedef logic [3:0] lsq_cnt_t;

  // destination register tag returned to the core
  typedef logic [3:0] wb_tag_t;

endpackage
